//--- filelist.f
rv32_pkg.sv
ir_decode.sv
ex_ctrl.sv
alu.sv
branch_alu.sv
ex_unit.sv
ex_pipe.sv
tb_clock_gen.sv
tb_ex_pipe.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ex_pipe
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "All tests passed" $(LOG); then echo "No pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_ex_pipe.sv
`default_nettype none

module tb_ex_pipe;
    import rv32_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int ALU_ROUNDS = 6;
    localparam int BR_ROUNDS  = 8;
    localparam int MEM_ROUNDS = 8;
    localparam int JMP_ROUNDS = 8;
    localparam int CSR_ROUNDS = 8;
    localparam int N_INSTR    = ALU_ROUNDS * 19 + BR_ROUNDS * 6 + MEM_ROUNDS * 4
                              + JMP_ROUNDS * 4 + CSR_ROUNDS * 6;
    // At most one gap cycle per instruction, plus reset and drain
    localparam int TIMEOUT    = (2 * N_INSTR + 100) * CLK_PERIOD;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] data1;
    logic [31:0] data2;
    logic [31:0] csr_data;
    logic        result_valid;
    logic [4:0]  rd;
    logic [31:0] rd_data;
    logic [31:0] alu_result;
    logic        branch_taken;

    // {check rd, taken, rd, rd_data, alu_result}
    logic [70:0] exp_q[$];
    int          cyc_q[$];
    logic [31:0] lcg_state;
    int          cycle_count = 0;
    int          errors = 0;
    int          checks = 0;
    int          results = 0;
    int          issued = 0;

    tb_clock_gen #(.PERIOD(CLK_PERIOD)) u_clock_gen (.clk(clk));

    ex_pipe dut0 (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .pc           (pc),
        .data1        (data1),
        .data2        (data2),
        .csr_data     (csr_data),
        .result_valid (result_valid),
        .rd           (rd),
        .rd_data      (rd_data),
        .alu_result   (alu_result),
        .branch_taken (branch_taken)
    );

    always @(posedge clk)
        cycle_count <= cycle_count + 1;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Biased second operand so that equal and edge values show up
    function automatic logic [31:0] related_operand(input logic [31:0] a);
        logic [31:0] r;
        r = lcg_next();
        case (r[2:0])
            3'd0:    return a;
            3'd1:    return {27'd0, r[31:27]};
            3'd2:    return 32'h8000_0000;
            3'd3:    return ~a;
            default: return lcg_next();
        endcase
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd_f);
        return {f7, rs2, rs1, f3, rd_f, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm12, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd_f,
                                          input logic [6:0] op);
        return {imm12, rs1, f3, rd_f, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm12, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm12[11:5], rs2, rs1, 3'b010, imm12[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm13, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm13[12], imm13[10:5], rs2, rs1, f3, imm13[4:1], imm13[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm21, input logic [4:0] rd_f);
        return {imm21[20], imm21[10:1], imm21[11], imm21[19:12], rd_f, 7'b1101111};
    endfunction

    function automatic logic [31:0] int_op(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'd0, $signed(a) < $signed(b)};
            3'b011:  return {31'd0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [70:0] expect_result(
        input ir_type_t t, input logic [2:0] f3, input logic f7b5, input logic [4:0] rd_f,
        input logic [31:0] imm_v, input logic [31:0] pc_v, input logic [31:0] a,
        input logic [31:0] b, input logic [31:0] csr_v);
        logic [31:0] alu_v;
        logic [31:0] wb;
        logic [31:0] src;
        logic        taken;
        logic        chk_rd;
        alu_v  = 32'd0;
        wb     = 32'd0;
        taken  = 1'b0;
        chk_rd = 1'b1;
        case (t)
            LUI_IR:
            begin
                alu_v = imm_v;
                wb    = imm_v;
            end
            AUIPC_IR:
            begin
                alu_v = pc_v + imm_v;
                wb    = alu_v;
            end
            JAL_IR:
            begin
                alu_v = pc_v + imm_v;
                wb    = pc_v + 32'd4;
                taken = 1'b1;
            end
            JALR_IR:
            begin
                alu_v = (a + imm_v) & 32'hFFFF_FFFE;
                wb    = pc_v + 32'd4;
                taken = 1'b1;
            end
            BRANCH_IR:
            begin
                alu_v  = pc_v + imm_v;
                taken  = branch_cond(f3, a, b);
                chk_rd = 1'b0;
            end
            LOAD_IR:
            begin
                alu_v = a + imm_v;
                wb    = alu_v;
            end
            STORE_IR:
            begin
                alu_v  = a + imm_v;
                chk_rd = 1'b0;
            end
            REG_IMM_IR:
            begin
                alu_v = int_op(f3, f3 == 3'b101 && f7b5, a, imm_v);
                wb    = alu_v;
            end
            REG_REG_IR:
            begin
                alu_v = int_op(f3, f7b5, a, b);
                wb    = alu_v;
            end
            SYS_CALL_IR:
            begin
                alu_v  = csr_v + imm_v;
                taken  = 1'b1;
                chk_rd = 1'b0;
            end
            CSR_IR:
            begin
                src = f3[2] ? imm_v : a;
                case (f3[1:0])
                    2'b01:   alu_v = src;
                    2'b10:   alu_v = csr_v | src;
                    default: alu_v = csr_v & ~src;
                endcase
                wb = csr_v;
            end
            default: chk_rd = 1'b0;
        endcase
        return {chk_rd, taken, rd_f, wb, alu_v};
    endfunction

    task automatic send_instr(input ir_type_t t, input logic [2:0] f3, input logic f7b5,
                              input logic [4:0] rd_f, input logic [31:0] imm_v,
                              input logic [31:0] word, input logic [31:0] pc_v,
                              input logic [31:0] a, input logic [31:0] b,
                              input logic [31:0] csr_v);
        logic [70:0] e;
        e = expect_result(t, f3, f7b5, rd_f, imm_v, pc_v, a, b, csr_v);
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = word;
        pc          = pc_v;
        data1       = a;
        data2       = b;
        csr_data    = csr_v;
        exp_q.push_back(e);
        cyc_q.push_back(cycle_count + 2);
        issued++;
    endtask

    task automatic idle_cycles(input int n);
        @(negedge clk);
        instr_valid = 1'b0;
        // Garbage while idle must not reach the outputs
        instr = lcg_next();
        repeat (n - 1) @(negedge clk);
    endtask

    task automatic maybe_gap();
        logic [31:0] r;
        r = lcg_next();
        if (r[1:0] == 2'b00)
            idle_cycles(1);
    endtask

    task automatic run_reg_ops(input int rounds);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm12;
        for (int i = 0; i < rounds; i++)
        begin
            for (int k = 0; k < 19; k++)
            begin
                a   = lcg_next();
                b   = related_operand(a);
                r   = lcg_next();
                alt = (k == 8 || k == 9 || k == 18);
                if (k < 10)
                begin
                    f3 = (k == 9) ? 3'b101 : 3'(k);
                    send_instr(REG_REG_IR, f3, alt, r[11:7], 32'd0,
                               enc_r({1'b0, alt, 5'd0}, r[24:20], r[19:15], f3, r[11:7]),
                               {r[31:2], 2'b00}, a, b, 32'd0);
                end
                else
                begin
                    f3 = (k == 18) ? 3'b101 : 3'(k - 10);
                    if (f3 == 3'b001 || f3 == 3'b101)
                        imm12 = {1'b0, alt, 5'd0, b[4:0]};
                    else
                        imm12 = b[11:0];
                    send_instr(REG_IMM_IR, f3, alt, r[11:7], {{20{imm12[11]}}, imm12},
                               enc_i(imm12, r[19:15], f3, r[11:7], 7'b0010011),
                               {r[31:2], 2'b00}, a, b, 32'd0);
                end
            end
        end
    endtask

    task automatic run_branch_ops(input int rounds);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [2:0]  f3;
        logic [12:0] imm13;
        for (int i = 0; i < rounds; i++)
        begin
            for (int k = 0; k < 6; k++)
            begin
                a     = lcg_next();
                b     = related_operand(a);
                r     = lcg_next();
                f3    = (k < 2) ? 3'(k) : 3'(k + 2);
                imm13 = {r[12:1], 1'b0};
                send_instr(BRANCH_IR, f3, 1'b0, 5'd0, {{19{imm13[12]}}, imm13},
                           enc_b(imm13, r[24:20], r[19:15], f3), {r[31:20], 20'h0}, a, b, 32'd0);
                maybe_gap();
            end
        end
    endtask

    task automatic run_upper_mem_ops(input int rounds);
        logic [31:0] a;
        logic [31:0] r;
        logic [31:0] pc_v;
        logic [11:0] imm12;
        for (int i = 0; i < rounds; i++)
        begin
            a     = lcg_next();
            r     = lcg_next();
            pc_v  = {a[31:2], 2'b00};
            imm12 = a[11:0];
            send_instr(LUI_IR, 3'd0, 1'b0, r[11:7], {r[31:12], 12'd0},
                       {r[31:12], r[11:7], 7'b0110111}, pc_v, a, r, 32'd0);
            send_instr(AUIPC_IR, 3'd0, 1'b0, r[11:7], {r[31:12], 12'd0},
                       {r[31:12], r[11:7], 7'b0010111}, pc_v, a, r, 32'd0);
            send_instr(LOAD_IR, 3'b010, 1'b0, r[11:7], {{20{imm12[11]}}, imm12},
                       enc_i(imm12, r[19:15], 3'b010, r[11:7], 7'b0000011), pc_v, r, a, 32'd0);
            send_instr(STORE_IR, 3'b010, 1'b0, 5'd0, {{20{imm12[11]}}, imm12},
                       enc_s(imm12, r[24:20], r[19:15]), pc_v, r, a, 32'd0);
        end
    endtask

    task automatic run_jump_ops(input int rounds);
        logic [31:0] a;
        logic [31:0] r;
        logic [31:0] pc_v;
        logic [20:0] imm21;
        for (int i = 0; i < rounds; i++)
        begin
            a     = lcg_next();
            r     = lcg_next();
            pc_v  = {r[31:2], 2'b00};
            imm21 = {a[20:1], 1'b0};
            send_instr(JAL_IR, 3'd0, 1'b0, r[11:7], {{11{imm21[20]}}, imm21},
                       enc_j(imm21, r[11:7]), pc_v, a, r, 32'd0);
            // Odd base address checks the cleared bit 0
            send_instr(JALR_IR, 3'd0, 1'b0, r[11:7], {{20{r[31]}}, r[31:20]},
                       enc_i(r[31:20], r[19:15], 3'd0, r[11:7], 7'b1100111), pc_v, a, r, 32'd0);
            maybe_gap();
            send_instr(SYS_CALL_IR, 3'd0, 1'b0, 5'd0, 32'd0, 32'h0000_0073, pc_v, a, r,
                       {a[15:0], r[15:0]});
            send_instr(SYS_CALL_IR, 3'd0, 1'b0, 5'd0, 32'd0, 32'h3020_0073, pc_v, r, a,
                       {r[15:0], a[15:0]});
            maybe_gap();
        end
    endtask

    task automatic run_csr_ops(input int rounds);
        logic [31:0] a;
        logic [31:0] r;
        logic [31:0] csr_v;
        logic [2:0]  f3;
        for (int i = 0; i < rounds; i++)
        begin
            for (int k = 0; k < 6; k++)
            begin
                a     = lcg_next();
                r     = lcg_next();
                csr_v = related_operand(a);
                f3    = (k < 3) ? 3'(k + 1) : 3'(k + 2);
                send_instr(CSR_IR, f3, 1'b0, r[11:7], {27'd0, r[19:15]},
                           enc_i(r[31:20], r[19:15], f3, r[11:7], 7'b1110011),
                           {a[31:2], 2'b00}, a, r, csr_v);
                maybe_gap();
            end
        end
    endtask

    always @(negedge clk)
    begin : compare_results
        logic [70:0] e;
        int          due;
        // Nothing is sampled before the first rising edge
        if (cycle_count != 0)
        begin
            if (reset)
            begin
                assert (result_valid === 1'b0 && branch_taken === 1'b0)
                else
                begin
                    errors++;
                    $display("result_valid or branch_taken is high during reset at time %0t",
                             $time);
                end
            end
            else if (result_valid === 1'b1)
            begin
                if (exp_q.size() == 0)
                begin
                    errors++;
                    $display("result_valid is high at time %0t with nothing in flight", $time);
                end
                else
                begin
                    e   = exp_q.pop_front();
                    due = cyc_q.pop_front();
                    results++;
                    checks += 5;
                    assert (due == cycle_count)
                    else
                    begin
                        errors++;
                        $display("[FAIL] t=%0t result_valid cycle: got %0d expected %0d",
                                 $time, cycle_count, due);
                    end
                    if (e[70])
                    begin
                        assert (rd === e[68:64])
                        else
                        begin
                            errors++;
                            $display("[FAIL] t=%0t rd: got %0d expected %0d",
                                     $time, rd, e[68:64]);
                        end
                    end
                    assert (rd_data === e[63:32])
                    else
                    begin
                        errors++;
                        $display("[FAIL] t=%0t rd_data: got %h expected %h",
                                 $time, rd_data, e[63:32]);
                    end
                    assert (alu_result === e[31:0])
                    else
                    begin
                        errors++;
                        $display("[FAIL] t=%0t alu_result: got %h expected %h",
                                 $time, alu_result, e[31:0]);
                    end
                    assert (branch_taken === e[69])
                    else
                    begin
                        errors++;
                        $display("[FAIL] t=%0t branch_taken: got %b expected %b",
                                 $time, branch_taken, e[69]);
                    end
                end
            end
            else if (result_valid !== 1'b0)
            begin
                errors++;
                $display("result_valid is unknown at time %0t", $time);
            end
            else if (cyc_q.size() != 0 && cyc_q[0] <= cycle_count)
            begin
                errors++;
                $display("Result missing at time %0t, expected in cycle %0d", $time, cyc_q[0]);
                e   = exp_q.pop_front();
                due = cyc_q.pop_front();
            end
        end
    end

    initial
    begin : watchdog
        #(TIMEOUT);
        $display("Watchdog expired after %0d time units with %0d results still pending",
                 TIMEOUT, exp_q.size());
        $display("Some tests failed");
        $finish;
    end

    initial
    begin
        lcg_state   = 32'd46;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = 32'd0;
        pc          = 32'd0;
        data1       = 32'd0;
        data2       = 32'd0;
        csr_data    = 32'd0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        idle_cycles(2);

        run_reg_ops(ALU_ROUNDS);
        idle_cycles(3);
        run_upper_mem_ops(MEM_ROUNDS);
        idle_cycles(2);
        run_branch_ops(BR_ROUNDS);
        idle_cycles(3);
        run_jump_ops(JMP_ROUNDS);
        idle_cycles(1);
        run_csr_ops(CSR_ROUNDS);
        idle_cycles(1);

        while (exp_q.size() != 0)
            @(negedge clk);
        repeat (4) @(negedge clk);

        $display("Issued %0d, results %0d, checks %0d, errors %0d",
                 issued, results, checks, errors);
        if (errors == 0 && results == issued)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 4
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- ex_pipe.sv
`default_nettype none

module ex_pipe (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       instr_valid,
    input  logic [31:0]                instr,
    input  logic [rv32_pkg::XLEN-1:0]  pc,
    input  logic [rv32_pkg::XLEN-1:0]  data1,
    input  logic [rv32_pkg::XLEN-1:0]  data2,
    input  logic [rv32_pkg::XLEN-1:0]  csr_data,
    output logic                       result_valid,
    output logic [4:0]                 rd,
    output logic [rv32_pkg::XLEN-1:0]  rd_data,
    output logic [rv32_pkg::XLEN-1:0]  alu_result,
    output logic                       branch_taken
);
    import rv32_pkg::*;

    logic            d_valid;
    ir_type_t        d_ir_type;
    logic [2:0]      d_funct3;
    logic [6:0]      d_funct7;
    logic [4:0]      d_rd;
    logic [XLEN-1:0] d_imm;
    logic [XLEN-1:0] d_pc;
    logic [XLEN-1:0] d_data1;
    logic [XLEN-1:0] d_data2;
    logic [XLEN-1:0] d_csr_data;

    ir_decode u_ir_decode (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .data1       (data1),
        .data2       (data2),
        .csr_data    (csr_data),
        .d_valid     (d_valid),
        .d_ir_type   (d_ir_type),
        .d_funct3    (d_funct3),
        .d_funct7    (d_funct7),
        .d_rd        (d_rd),
        .d_imm       (d_imm),
        .d_pc        (d_pc),
        .d_data1     (d_data1),
        .d_data2     (d_data2),
        .d_csr_data  (d_csr_data)
    );

    ex_unit u_ex_unit (
        .clk          (clk),
        .reset        (reset),
        .d_valid      (d_valid),
        .d_ir_type    (d_ir_type),
        .d_funct3     (d_funct3),
        .d_funct7     (d_funct7),
        .d_rd         (d_rd),
        .d_imm        (d_imm),
        .d_pc         (d_pc),
        .d_data1      (d_data1),
        .d_data2      (d_data2),
        .d_csr_data   (d_csr_data),
        .result_valid (result_valid),
        .rd           (rd),
        .rd_data      (rd_data),
        .alu_result   (alu_result),
        .branch_taken (branch_taken)
    );

endmodule

`default_nettype wire

//--- ex_unit.sv
`default_nettype none

module ex_unit (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       d_valid,
    input  rv32_pkg::ir_type_t         d_ir_type,
    input  logic [2:0]                 d_funct3,
    input  logic [6:0]                 d_funct7,
    input  logic [4:0]                 d_rd,
    input  logic [rv32_pkg::XLEN-1:0]  d_imm,
    input  logic [rv32_pkg::XLEN-1:0]  d_pc,
    input  logic [rv32_pkg::XLEN-1:0]  d_data1,
    input  logic [rv32_pkg::XLEN-1:0]  d_data2,
    input  logic [rv32_pkg::XLEN-1:0]  d_csr_data,
    output logic                       result_valid,
    output logic [4:0]                 rd,
    output logic [rv32_pkg::XLEN-1:0]  rd_data,
    output logic [rv32_pkg::XLEN-1:0]  alu_result,
    output logic                       branch_taken
);
    import rv32_pkg::*;

    logic [XLEN-1:0] in1;
    logic [XLEN-1:0] in2;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] wb_data;
    alu_op_t         alu_op;
    branch_op_t      branch_op;
    logic            taken;

    ex_ctrl u_ex_ctrl (
        .ir_type   (d_ir_type),
        .funct3    (d_funct3),
        .funct7    (d_funct7),
        .data1     (d_data1),
        .data2     (d_data2),
        .pc        (d_pc),
        .imm       (d_imm),
        .csr_data  (d_csr_data),
        .in1       (in1),
        .in2       (in2),
        .branch_op (branch_op),
        .alu_op    (alu_op)
    );

    alu u_alu (
        .alu_op (alu_op),
        .in1    (in1),
        .in2    (in2),
        .result (alu_out)
    );

    branch_alu u_branch_alu (
        .branch_op (branch_op),
        .data1     (d_data1),
        .data2     (d_data2),
        .taken     (taken)
    );

    // Link address for jumps, old CSR value for CSR ops
    always_comb
    begin
        case (d_ir_type)
            JAL_IR, JALR_IR:                  wb_data = d_pc + 32'd4;
            CSR_IR:                           wb_data = d_csr_data;
            BRANCH_IR, STORE_IR, SYS_CALL_IR: wb_data = '0;
            default:                          wb_data = alu_out;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            result_valid <= 1'b0;
            branch_taken <= 1'b0;
        end
        else
        begin
            result_valid <= d_valid;
            branch_taken <= d_valid && taken;
        end
        if (d_valid)
        begin
            rd         <= d_rd;
            rd_data    <= wb_data;
            alu_result <= alu_out;
        end
    end

    taken_needs_valid: assert property (@(posedge clk) disable iff (reset)
        branch_taken |-> result_valid);

endmodule

`default_nettype wire

//--- branch_alu.sv
`default_nettype none

module branch_alu (
    input  rv32_pkg::branch_op_t       branch_op,
    input  logic [rv32_pkg::XLEN-1:0]  data1,
    input  logic [rv32_pkg::XLEN-1:0]  data2,
    output logic                       taken
);
    import rv32_pkg::*;

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = data1 == data2;
    assign lt  = $signed(data1) < $signed(data2);
    assign ltu = data1 < data2;

    always_comb
    begin
        case (branch_op)
            BEQ:     taken = eq;
            BNE:     taken = !eq;
            BLT:     taken = lt;
            BGE:     taken = !lt;
            BLTU:    taken = ltu;
            BGEU:    taken = !ltu;
            JUMP:    taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- alu.sv
`default_nettype none

module alu (
    input  rv32_pkg::alu_op_t          alu_op,
    input  logic [rv32_pkg::XLEN-1:0]  in1,
    input  logic [rv32_pkg::XLEN-1:0]  in2,
    output logic [rv32_pkg::XLEN-1:0]  result
);
    import rv32_pkg::*;

    logic [4:0]      shamt;
    logic [XLEN-1:0] sum;

    assign shamt = in2[4:0];
    assign sum   = in1 + in2;

    always_comb
    begin
        case (alu_op)
            ADD:    result = sum;
            SUB:    result = in1 - in2;
            SLL:    result = in1 << shamt;
            SLT:    result = {31'b0, $signed(in1) < $signed(in2)};
            SLTU:   result = {31'b0, in1 < in2};
            XOR:    result = in1 ^ in2;
            SRL:    result = in1 >> shamt;
            SRA:    result = $unsigned($signed(in1) >>> shamt);
            OR:     result = in1 | in2;
            AND:    result = in1 & in2;
            CP_IN2: result = in2;
            // Target of JALR is always halfword aligned
            JALR:   result = {sum[XLEN-1:1], 1'b0};
            CSRRC:  result = in1 & ~in2;
            default:
                result = '0;
        endcase
    end

    always_comb
    begin
        alu_op_known: assert #0 (!$isunknown(alu_op));
    end

endmodule

`default_nettype wire

//--- ex_ctrl.sv
`default_nettype none

module ex_ctrl (
    input  rv32_pkg::ir_type_t         ir_type,
    input  logic [2:0]                 funct3,
    input  logic [6:0]                 funct7,
    input  logic [rv32_pkg::XLEN-1:0]  data1,
    input  logic [rv32_pkg::XLEN-1:0]  data2,
    input  logic [rv32_pkg::XLEN-1:0]  pc,
    input  logic [rv32_pkg::XLEN-1:0]  imm,
    input  logic [rv32_pkg::XLEN-1:0]  csr_data,
    output logic [rv32_pkg::XLEN-1:0]  in1,
    output logic [rv32_pkg::XLEN-1:0]  in2,
    output rv32_pkg::branch_op_t       branch_op,
    output rv32_pkg::alu_op_t          alu_op
);
    import rv32_pkg::*;

    alu_op_t reg_imm_op;

    // Operand selection
    always_comb
    begin
        case (ir_type)
            LUI_IR, AUIPC_IR, JAL_IR, BRANCH_IR:
            begin
                in1 = pc;
                in2 = imm;
            end
            JALR_IR, LOAD_IR, STORE_IR, REG_IMM_IR:
            begin
                in1 = data1;
                in2 = imm;
            end
            SYS_CALL_IR:
            begin
                in1 = csr_data;
                in2 = imm;
            end
            // Immediate form takes zimm, register form takes rs1
            CSR_IR:
            begin
                in1 = csr_data;
                in2 = funct3[2] ? imm : data1;
            end
            default:
            begin
                in1 = data1;
                in2 = data2;
            end
        endcase
    end

    // Immediate arithmetic has no SUB, funct7 only picks SRAI
    always_comb
    begin
        case (funct3)
            ADD_FUNCT3, SLL_FUNCT3, SLT_FUNCT3, SLTU_FUNCT3,
            XOR_FUNCT3, OR_FUNCT3, AND_FUNCT3:
                reg_imm_op = alu_op_t'({1'b0, funct3});
            SR_FUNCT3:
                reg_imm_op = alu_op_t'({funct7[5], funct3});
            default:
                reg_imm_op = X_ALU_OP;
        endcase
    end

    always_comb
    begin
        case (ir_type)
            LUI_IR:     alu_op = CP_IN2;
            JALR_IR:    alu_op = JALR;
            REG_REG_IR: alu_op = alu_op_t'({funct7[5], funct3});
            REG_IMM_IR: alu_op = reg_imm_op;
            CSR_IR:
            begin
                case (funct3[1:0])
                    2'b01:   alu_op = CP_IN2;
                    2'b10:   alu_op = OR;
                    2'b11:   alu_op = CSRRC;
                    default: alu_op = X_ALU_OP;
                endcase
            end
            default:    alu_op = ADD;
        endcase
    end

    always_comb
    begin
        case (ir_type)
            JAL_IR, JALR_IR, SYS_CALL_IR: branch_op = JUMP;
            BRANCH_IR:                    branch_op = branch_op_t'(funct3);
            default:                      branch_op = NO_JUMP;
        endcase
    end

endmodule

`default_nettype wire

//--- ir_decode.sv
`default_nettype none

module ir_decode (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       instr_valid,
    input  logic [31:0]                instr,
    input  logic [rv32_pkg::XLEN-1:0]  pc,
    input  logic [rv32_pkg::XLEN-1:0]  data1,
    input  logic [rv32_pkg::XLEN-1:0]  data2,
    input  logic [rv32_pkg::XLEN-1:0]  csr_data,
    output logic                       d_valid,
    output rv32_pkg::ir_type_t         d_ir_type,
    output logic [2:0]                 d_funct3,
    output logic [6:0]                 d_funct7,
    output logic [4:0]                 d_rd,
    output logic [rv32_pkg::XLEN-1:0]  d_imm,
    output logic [rv32_pkg::XLEN-1:0]  d_pc,
    output logic [rv32_pkg::XLEN-1:0]  d_data1,
    output logic [rv32_pkg::XLEN-1:0]  d_data2,
    output logic [rv32_pkg::XLEN-1:0]  d_csr_data
);
    import rv32_pkg::*;

    ir_type_t        ir_type;
    logic [XLEN-1:0] imm;
    logic [6:0]      opcode;

    assign opcode = instr[6:0];

    always_comb
    begin
        ir_type = ILLEGAL_IR;
        imm     = {{20{instr[31]}}, instr[31:20]};
        case (opcode)
            7'b0110111:
            begin
                ir_type = LUI_IR;
                imm     = {instr[31:12], 12'b0};
            end
            7'b0010111:
            begin
                ir_type = AUIPC_IR;
                imm     = {instr[31:12], 12'b0};
            end
            7'b1101111:
            begin
                ir_type = JAL_IR;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            7'b1100111: ir_type = JALR_IR;
            7'b1100011:
            begin
                ir_type = BRANCH_IR;
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            7'b0000011: ir_type = LOAD_IR;
            7'b0100011:
            begin
                ir_type = STORE_IR;
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            7'b0010011: ir_type = REG_IMM_IR;
            7'b0110011: ir_type = REG_REG_IR;
            7'b1110011:
            begin
                // funct3 zero is mret/ecall, jump straight to the CSR value
                if (instr[14:12] == 3'b000)
                begin
                    ir_type = SYS_CALL_IR;
                    imm     = '0;
                end
                else
                begin
                    ir_type = CSR_IR;
                    imm     = {27'b0, instr[19:15]};
                end
            end
            default: ir_type = ILLEGAL_IR;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            d_valid <= 1'b0;
        else
            d_valid <= instr_valid;
        if (instr_valid)
        begin
            d_ir_type  <= ir_type;
            d_funct3   <= instr[14:12];
            d_funct7   <= instr[31:25];
            d_rd       <= instr[11:7];
            d_imm      <= imm;
            d_pc       <= pc;
            d_data1    <= data1;
            d_data2    <= data2;
            d_csr_data <= csr_data;
        end
    end

    d_type_known: assert property (@(posedge clk) disable iff (reset)
        d_valid |-> !$isunknown(d_ir_type));

endmodule

`default_nettype wire

//--- rv32_pkg.sv
`default_nettype none

package rv32_pkg;

    localparam int XLEN = 32;

    // Instruction class from the opcode
    typedef enum logic [3:0] {
        LUI_IR      = 4'd0,
        AUIPC_IR    = 4'd1,
        JAL_IR      = 4'd2,
        JALR_IR     = 4'd3,
        BRANCH_IR   = 4'd4,
        LOAD_IR     = 4'd5,
        STORE_IR    = 4'd6,
        REG_IMM_IR  = 4'd7,
        REG_REG_IR  = 4'd8,
        SYS_CALL_IR = 4'd9,
        CSR_IR      = 4'd10,
        ILLEGAL_IR  = 4'd11
    } ir_type_t;

    // funct7[5] followed by funct3, plus a few special codes
    typedef enum logic [3:0] {
        ADD      = 4'b0000,
        SLL      = 4'b0001,
        SLT      = 4'b0010,
        SLTU     = 4'b0011,
        XOR      = 4'b0100,
        SRL      = 4'b0101,
        OR       = 4'b0110,
        AND      = 4'b0111,
        SUB      = 4'b1000,
        CP_IN2   = 4'b1001,
        JALR     = 4'b1010,
        CSRRC    = 4'b1011,
        SRA      = 4'b1101,
        X_ALU_OP = 4'b1111
    } alu_op_t;

    // Branch codes equal funct3 of the branch instruction
    typedef enum logic [2:0] {
        BEQ     = 3'b000,
        BNE     = 3'b001,
        JUMP    = 3'b010,
        NO_JUMP = 3'b011,
        BLT     = 3'b100,
        BGE     = 3'b101,
        BLTU    = 3'b110,
        BGEU    = 3'b111
    } branch_op_t;

    localparam logic [2:0] ADD_FUNCT3  = 3'b000;
    localparam logic [2:0] SLL_FUNCT3  = 3'b001;
    localparam logic [2:0] SLT_FUNCT3  = 3'b010;
    localparam logic [2:0] SLTU_FUNCT3 = 3'b011;
    localparam logic [2:0] XOR_FUNCT3  = 3'b100;
    localparam logic [2:0] SR_FUNCT3   = 3'b101;
    localparam logic [2:0] OR_FUNCT3   = 3'b110;
    localparam logic [2:0] AND_FUNCT3  = 3'b111;

endpackage

`default_nettype wire
